// File: rtl/i2c_pkg.sv
// I2C master shared widths, frame timing and bus types
`default_nettype none

package i2c_pkg;

    //******************************
    // widths
    //******************************
    localparam int STEP_W  = 7;                   // quarter-bit steps within a frame
    localparam int BURST_W = 8;                   // bytes per burst

    typedef logic [6:0]         slave_addr_t;
    typedef logic [15:0]        word_addr_t;
    typedef logic [7:0]         data_byte_t;
    typedef logic [STEP_W-1:0]  step_t;
    typedef logic [BURST_W-1:0] burst_len_t;

    //******************************
    // frame timing, in steps
    //******************************
    localparam step_t START_FRAME_END = step_t'(43);  // start + 8 bits + ack
    localparam step_t BYTE_FRAME_END  = step_t'(39);  // 8 bits + ack
    localparam step_t STOP_FRAME_END  = step_t'(6);
    localparam step_t PREAMBLE_STEPS  = step_t'(4);   // (re)start ahead of the address
    localparam step_t BIT_STEPS       = step_t'(32);  // eight bits of four steps each

    // frame being sent
    typedef enum logic [2:0] {
        st_idle,
        st_sladdr,
        st_addr16,
        st_addr8,
        st_data_wr,
        st_addr_rd,
        st_data_rd,
        st_stop
    } i2c_state_e;

    typedef struct packed {
        logic       rh_wl;                        // 1 = read
        logic       bit_ctrl;                     // 1 = 16-bit word address
        word_addr_t word_addr;
        burst_len_t reg_num;
    } i2c_req_t;

    typedef struct packed {
        logic scl;
        logic sda_out;
        logic sda_oe;
    } i2c_line_t;

    localparam i2c_line_t IDLE_LINE = '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b0};

endpackage

`default_nettype wire

// File: rtl/i2c_step_timer.sv
// I2C step timer counting quarter-bit steps per frame and bytes per burst
`timescale 1ns/100ps
`default_nettype none

module i2c_step_timer
    import i2c_pkg::*;
(
    input  wire             dri_clk,
    input  wire             rst_n,
    input  var i2c_state_e  state,
    input  var burst_len_t  reg_num,
    input  wire             byte_done,
    output step_t           step,
    output logic            frame_done,
    output logic            last_byte
);

    step_t      end_step;
    burst_len_t byte_cnt;                         // bytes strobed so far
    logic       byte_seen;                        // strobe of this frame already counted

    always_comb begin
        case (state)
            st_sladdr, st_addr_rd: end_step = START_FRAME_END;
            st_stop:               end_step = STOP_FRAME_END;
            default:               end_step = BYTE_FRAME_END;
        endcase
    end

    assign frame_done = (state != st_idle) && (step == end_step);

    //******************************
    // step counter
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            step <= '0;
        else if (state == st_idle || frame_done)
            step <= '0;
        else
            step <= step + 1'b1;
    end

    //******************************
    // burst byte counter
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt  <= '0;
            byte_seen <= 1'b0;
        end else if (state == st_idle) begin
            byte_cnt  <= '0;
            byte_seen <= 1'b0;
        end else if (byte_done) begin
            byte_cnt  <= byte_cnt + 1'b1;
            byte_seen <= 1'b1;
        end else if (frame_done) begin
            byte_seen <= 1'b0;
        end
    end

    // before the strobe the byte in flight is byte_cnt + 1, after it byte_cnt
    // so the level holds from the master ack slot through the frame end
    assign last_byte = byte_seen ? (byte_cnt == reg_num)
                                 : (burst_len_t'(byte_cnt + 1'b1) == reg_num);

endmodule

`default_nettype wire

// File: rtl/i2c_ctrl_fsm.sv
// I2C control FSM sequencing address, data and stop frames of a transfer
`timescale 1ns/100ps
`default_nettype none

module i2c_ctrl_fsm
    import i2c_pkg::*;
(
    input  wire             dri_clk,
    input  wire             rst_n,
    input  wire             i2c_exec,
    input  wire             i2c_rh_wl,
    input  wire             bit_ctrl,
    input  var word_addr_t  i2c_addr,
    input  var burst_len_t  reg_num,
    input  wire             frame_done,
    input  wire             last_byte,
    input  wire             ack,                  // high = slave NACK
    output i2c_state_e      state,
    output i2c_req_t        req,
    output logic            i2c_done
);

    i2c_state_e next_state;

    //******************************
    // next state
    //******************************
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (i2c_exec)
                    next_state = st_sladdr;
            end
            st_sladdr: begin
                if (frame_done) begin
                    if (ack)
                        next_state = st_stop;     // no device answered
                    else if (req.bit_ctrl)
                        next_state = st_addr16;
                    else
                        next_state = st_addr8;
                end
            end
            st_addr16: begin
                if (frame_done)
                    next_state = ack ? st_stop : st_addr8;
            end
            st_addr8: begin
                if (frame_done) begin
                    if (ack)
                        next_state = st_stop;
                    else if (req.rh_wl)
                        next_state = st_addr_rd;  // repeated start for the read
                    else
                        next_state = st_data_wr;
                end
            end
            st_data_wr: begin
                if (frame_done && (ack || last_byte))
                    next_state = st_stop;
            end
            st_addr_rd: begin
                if (frame_done)
                    next_state = ack ? st_stop : st_data_rd;
            end
            st_data_rd: begin
                if (frame_done && last_byte)
                    next_state = st_stop;
            end
            st_stop: begin
                if (frame_done)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    //******************************
    // state and request registers
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            req      <= '0;
            i2c_done <= 1'b0;
        end else begin
            state    <= next_state;
            i2c_done <= (state == st_stop) && frame_done;  // one cycle after stop ends
            if (state == st_idle && i2c_exec) begin
                req.rh_wl     <= i2c_rh_wl;
                req.bit_ctrl  <= bit_ctrl;
                req.word_addr <= i2c_addr;
                req.reg_num   <= reg_num;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2c_bit_engine.sv
// I2C line engine driving SCL and SDA per step, shifting bytes and handling ack
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  wire              dri_clk,
    input  wire              rst_n,
    input  var i2c_state_e   state,
    input  var step_t        step,
    input  var slave_addr_t  slave_addr,
    input  var i2c_req_t     req,
    input  var data_byte_t   i2c_data_w,
    input  wire              last_byte,
    input  wire              sda_in,
    output i2c_line_t        line,
    output logic             ack,               // last slave ack bit, high = NACK
    output logic             byte_done,
    output data_byte_t       i2c_data_r
);

    logic       is_start;                         // frame opens with a (re)start
    logic       is_byte;
    logic       in_bits;                          // past the preamble
    logic       rd_frame;
    step_t      bstep;                            // step relative to the first bit
    data_byte_t tx_byte;
    data_byte_t tx_shift;
    data_byte_t rx_shift;
    logic       tx_bit;

    assign is_start = (state == st_sladdr) || (state == st_addr_rd);
    assign is_byte  = (state == st_addr16) || (state == st_addr8) ||
                      (state == st_data_wr) || (state == st_data_rd);
    assign rd_frame = (state == st_data_rd);
    assign bstep    = is_start ? step - PREAMBLE_STEPS : step;
    assign in_bits  = is_byte || (is_start && step >= PREAMBLE_STEPS);

    always_comb begin
        case (state)
            st_sladdr:  tx_byte = {slave_addr, 1'b0};     // write direction
            st_addr_rd: tx_byte = {slave_addr, 1'b1};     // read direction
            st_addr16:  tx_byte = req.word_addr[15:8];
            st_addr8:   tx_byte = req.word_addr[7:0];
            default:    tx_byte = i2c_data_w;             // taken at the first bit
        endcase
    end

    assign tx_bit = (bstep == '0) ? tx_byte[7] : tx_shift[7];

    //******************************
    // SCL / SDA sequencing
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            line      <= IDLE_LINE;
            ack       <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (state == st_idle) begin
                line <= IDLE_LINE;
            end else if (state == st_stop) begin
                case (step)
                    0: begin
                        line.sda_oe  <= 1'b1;
                        line.sda_out <= 1'b0;
                    end
                    1: line.scl     <= 1'b1;
                    3: line.sda_out <= 1'b1;              // stop, SDA rises with SCL high
                    default: ;
                endcase
            end else if (!in_bits) begin
                case (step[1:0])
                    2'd0: begin
                        line.sda_oe  <= 1'b1;
                        line.sda_out <= 1'b1;
                    end
                    2'd1: line.scl     <= 1'b1;
                    2'd2: line.sda_out <= 1'b0;           // start, SDA falls with SCL high
                    default: line.scl  <= 1'b0;
                endcase
            end else if (bstep < BIT_STEPS) begin
                case (bstep[1:0])
                    2'd0: begin
                        line.sda_oe  <= !rd_frame;        // slave drives read bits
                        line.sda_out <= rd_frame ? 1'b1 : tx_bit;
                    end
                    2'd1: line.scl <= 1'b1;
                    2'd3: line.scl <= 1'b0;
                    default: ;
                endcase
            end else begin
                case (bstep)
                    32: begin
                        line.sda_oe  <= rd_frame;         // master answers read bytes
                        line.sda_out <= rd_frame ? last_byte : 1'b1;
                        byte_done    <= (state == st_data_wr);
                    end
                    33: begin
                        line.scl  <= 1'b1;
                        byte_done <= rd_frame;
                    end
                    34: begin
                        if (!rd_frame)
                            ack <= sda_in;                // mid SCL high
                    end
                    39: line.scl <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    //******************************
    // byte shifters
    //******************************
    always_ff @(posedge dri_clk) begin
        if (in_bits && bstep < BIT_STEPS) begin
            if (bstep[1:0] == 2'd0)
                tx_shift <= (bstep == '0) ? tx_byte << 1 : tx_shift << 1;
            if (rd_frame && bstep[1:0] == 2'd2)
                rx_shift <= {rx_shift[6:0], sda_in};  // msb first
        end
        if (rd_frame && bstep == 33)
            i2c_data_r <= rx_shift;
    end

endmodule

`default_nettype wire

// File: rtl/i2c_master_top.sv
// I2C master top level joining control FSM, step timer and line engine
`timescale 1ns/100ps
`default_nettype none

module i2c_master_top
    import i2c_pkg::*;
(
    input  wire              dri_clk,             // four steps per SCL period
    input  wire              rst_n,
    input  var slave_addr_t  slave_addr,
    input  wire              i2c_exec,
    input  wire              i2c_rh_wl,
    input  wire              bit_ctrl,
    input  var word_addr_t   i2c_addr,
    input  var data_byte_t   i2c_data_w,
    input  var burst_len_t   reg_num,
    output data_byte_t       i2c_data_r,
    output logic             i2c_done,
    output logic             once_byte_done,
    output logic             ack,
    output logic             scl,
    inout  wire              sda
);

    i2c_state_e state;
    i2c_req_t   req;
    step_t      step;
    logic       frame_done;
    logic       last_byte;
    i2c_line_t  line;

    i2c_ctrl_fsm i2c_ctrl_fsm_inst (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .i2c_rh_wl  (i2c_rh_wl),
        .bit_ctrl   (bit_ctrl),
        .i2c_addr   (i2c_addr),
        .reg_num    (reg_num),
        .frame_done (frame_done),
        .last_byte  (last_byte),
        .ack        (ack),
        .state      (state),
        .req        (req),
        .i2c_done   (i2c_done)
    );

    i2c_step_timer i2c_step_timer_inst (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .state      (state),
        .reg_num    (req.reg_num),           // latched burst length
        .byte_done  (once_byte_done),
        .step       (step),
        .frame_done (frame_done),
        .last_byte  (last_byte)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .state      (state),
        .step       (step),
        .slave_addr (slave_addr),
        .req        (req),
        .i2c_data_w (i2c_data_w),
        .last_byte  (last_byte),
        .sda_in     (sda),
        .line       (line),
        .ack        (ack),
        .byte_done  (once_byte_done),
        .i2c_data_r (i2c_data_r)
    );

    // open drain, the pull-up supplies the high level
    assign sda = (line.sda_oe && !line.sda_out) ? 1'b0 : 1'bz;
    assign scl = line.scl;

endmodule

`default_nettype wire

// File: testbench/i2c_slave_model.sv
// Behavioral I2C slave with an auto-incrementing byte memory and a log of master acks
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_model
    import i2c_pkg::*;
(
    input  wire         scl,
    inout  wire         sda,
    input  wire         wide_addr,              // two word-address bytes
    output logic [15:0] ack_bits,               // newest master ack in bit 0
    output logic [7:0]  ack_count
);

    localparam slave_addr_t DEV_ADDR = 7'h50;

    typedef enum {ph_idle, ph_dev, ph_word_hi, ph_word_lo, ph_write, ph_read} phase_e;

    phase_e     phase;
    logic [7:0] mem [0:255];
    logic [7:0] ptr;                            // low 8 bits of the word address
    logic [7:0] shift;
    logic [7:0] tx;
    int         bit_cnt;                        // 0..7 data bits, 8 ack slot
    logic       got_rise;                       // scl rose since the last start
    logic       slave_acking;
    logic       nack_seen;
    logic       drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        phase        = ph_idle;
        ptr          = '0;
        shift        = '0;
        tx           = '0;
        bit_cnt      = 0;
        got_rise     = 1'b0;
        slave_acking = 1'b0;
        nack_seen    = 1'b0;
        drive_low    = 1'b0;
        ack_bits     = '0;
        ack_count    = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i) ^ 8'h5a;             // fill tied to the address
    end

    //******************************
    // start and stop
    //******************************
    always @(negedge sda) begin
        if (scl === 1'b1) begin                 // start or repeated start
            phase        = ph_dev;
            bit_cnt      = 0;
            got_rise     = 1'b0;
            slave_acking = 1'b0;
            nack_seen    = 1'b0;
            drive_low    = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            phase     = ph_idle;
            got_rise  = 1'b0;
            drive_low = 1'b0;
        end
    end

    //******************************
    // bit sampling on scl rise
    //******************************
    always @(posedge scl) begin
        if (phase != ph_idle) begin
            got_rise = 1'b1;
            if (bit_cnt < 8) begin
                if (phase != ph_read)
                    shift = {shift[6:0], sda};
            end else if (phase == ph_read && !slave_acking) begin
                ack_bits  = {ack_bits[14:0], sda};
                ack_count = ack_count + 1'b1;
                nack_seen = (sda !== 1'b0);
            end
        end
    end

    //******************************
    // byte handling on scl fall
    //******************************
    always @(negedge scl) begin
        if (phase != ph_idle && got_rise) begin
            got_rise = 1'b0;
            if (bit_cnt < 7) begin
                bit_cnt = bit_cnt + 1;
                if (phase == ph_read)
                    drive_low = !tx[7 - bit_cnt];
            end else if (bit_cnt == 7) begin
                bit_cnt = 8;
                slave_acking = (phase != ph_read);
                drive_low    = slave_acking;
                case (phase)
                    ph_dev: begin
                        if (shift[7:1] != DEV_ADDR) begin
                            phase        = ph_idle;     // not addressed, stay off the bus
                            slave_acking = 1'b0;
                            drive_low    = 1'b0;
                        end else if (shift[0])
                            phase = ph_read;
                        else
                            phase = wide_addr ? ph_word_hi : ph_word_lo;
                    end
                    ph_word_hi: phase = ph_word_lo;     // high byte beyond the memory
                    ph_word_lo: begin
                        ptr   = shift;
                        phase = ph_write;
                    end
                    ph_write: begin
                        mem[ptr] = shift;
                        ptr      = ptr + 1'b1;
                    end
                    default: ;
                endcase
            end else begin
                bit_cnt   = 0;
                drive_low = 1'b0;
                if (phase == ph_read) begin
                    if (nack_seen) begin
                        phase = ph_idle;                // master ended the burst
                    end else begin
                        tx        = mem[ptr];
                        ptr       = ptr + 1'b1;
                        drive_low = !tx[7];
                    end
                end
                slave_acking = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_i2c_master.sv
// Testbench for the I2C master, replaying a transfer trace against a slave model
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 5000;
    localparam int          MAX_BYTES      = 8;
    localparam slave_addr_t TARGET_ADDR    = 7'h50;

    logic        dri_clk;
    logic        rst_n;
    slave_addr_t slave_addr;
    logic        i2c_exec;
    logic        i2c_rh_wl;
    logic        bit_ctrl;
    word_addr_t  i2c_addr;
    data_byte_t  i2c_data_w;
    burst_len_t  reg_num;
    data_byte_t  i2c_data_r;
    logic        i2c_done;
    logic        once_byte_done;
    logic        ack;
    logic        scl;
    wire         sda;
    logic        wide_addr;
    logic [15:0] ack_bits;
    logic [7:0]  ack_count;

    data_byte_t  xfer_bytes [0:MAX_BYTES-1];
    logic [31:0] fld [0:14];                    // one parsed trace line
    string       line_str;
    int          fd;
    int          cnt;
    int          cur_test;
    int          test_errors;
    int          tests_run;
    int          checks;
    int          errors;
    int          transfers;
    int          k;
    logic        timed_out;

    pullup (sda);

    i2c_master_top i2c_master_top_inst (
        .dri_clk        (dri_clk),
        .rst_n          (rst_n),
        .slave_addr     (slave_addr),
        .i2c_exec       (i2c_exec),
        .i2c_rh_wl      (i2c_rh_wl),
        .bit_ctrl       (bit_ctrl),
        .i2c_addr       (i2c_addr),
        .i2c_data_w     (i2c_data_w),
        .reg_num        (reg_num),
        .i2c_data_r     (i2c_data_r),
        .i2c_done       (i2c_done),
        .once_byte_done (once_byte_done),
        .ack            (ack),
        .scl            (scl),
        .sda            (sda)
    );

    i2c_slave_model i2c_slave_model_inst (
        .scl       (scl),
        .sda       (sda),
        .wide_addr (wide_addr),
        .ack_bits  (ack_bits),
        .ack_count (ack_count)
    );

    initial begin
        dri_clk = 1'b0;
        forever #5 dri_clk = ~dri_clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic print_test_result(input int id, input int errs);
        tests_run++;
        $display("test %0d finished with %0d errors", id, errs);
    endtask

    //******************************
    // one transfer, checked at every strobe
    //******************************
    task automatic run_transfer(input logic rd, input slave_addr_t dev, input logic wide,
                                input word_addr_t addr, input int n, input int gap);
        int         cycles;
        int         strobes;
        int         i;
        logic       finished;
        logic       expect_nack;
        logic [7:0] acks_before;
        logic [7:0] acks_taken;

        expect_nack = (dev != TARGET_ADDR);         // only the model answers
        acks_before = ack_count;
        strobes     = 0;
        cycles      = 0;
        finished    = 1'b0;
        transfers++;
        @(posedge dri_clk);
        check_value(i2c_done, 1'b0, "i2c_done longer than one cycle");
        repeat (gap) @(posedge dri_clk);
        slave_addr <= dev;
        i2c_rh_wl  <= rd;
        bit_ctrl   <= wide;
        wide_addr  <= wide;
        i2c_addr   <= addr;
        reg_num    <= burst_len_t'(n);
        i2c_data_w <= xfer_bytes[0];
        i2c_exec   <= 1'b1;
        while (!finished && cycles < TIMEOUT_CYCLES) begin
            @(posedge dri_clk);
            cycles++;
            i2c_exec <= 1'b0;
            if (once_byte_done) begin
                if (rd && strobes < n)
                    check_value(i2c_data_r, xfer_bytes[strobes],
                                $sformatf("read byte %0d of transfer %0d", strobes, transfers));
                else if (!rd && strobes + 1 < n)
                    i2c_data_w <= xfer_bytes[strobes + 1];   // next byte before step 0
                strobes++;
            end
            if (i2c_done)
                finished = 1'b1;
        end
        if (!finished) begin
            $display("Transfer %0d never finished: no i2c_done within %0d cycles",
                     transfers, TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value(ack, expect_nack, $sformatf("ack after transfer %0d", transfers));
            check_value(strobes, expect_nack ? 0 : n,
                        $sformatf("once_byte_done count in transfer %0d", transfers));
            if (rd && !expect_nack) begin
                acks_taken = ack_count - acks_before;
                check_value(acks_taken, n, $sformatf("master acks in transfer %0d", transfers));
                for (i = 0; i < n; i++)
                    check_value(ack_bits[i], (i == 0),
                                $sformatf("master ack for byte %0d of %0d", n - i, n));
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        slave_addr = '0;
        i2c_exec   = 1'b0;
        i2c_rh_wl  = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        reg_num    = '0;
        wide_addr  = 1'b0;
        tests_run  = 0;
        checks     = 0;
        errors     = 0;
        transfers  = 0;
        cur_test   = 0;
        timed_out  = 1'b0;
        repeat (16) @(posedge dri_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge dri_clk);

        // idle bus before any request
        check_value(scl, 1'b1, "scl after reset");
        check_value(sda, 1'b1, "sda after reset");
        check_value(i2c_done, 1'b0, "i2c_done after reset");
        check_value(once_byte_done, 1'b0, "once_byte_done after reset");
        check_value(ack, 1'b0, "ack after reset");
        print_test_result(1, errors);

        fd = $fopen("testbench/i2c_master_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file testbench/i2c_master_trace.txt");
            errors++;
        end else begin
            test_errors = errors;
            while (!timed_out && $fgets(line_str, fd) != 0) begin
                cnt = $sscanf(line_str, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                              fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
                if (cnt > 0 && (cnt < 7 || cnt != 7 + fld[6])) begin
                    $display("Malformed trace line: %s", line_str);
                    errors++;
                end else if (cnt > 0) begin
                    if (fld[0] != cur_test) begin
                        if (cur_test != 0)
                            print_test_result(cur_test, errors - test_errors);
                        cur_test    = fld[0];
                        test_errors = errors;
                    end
                    for (k = 0; k < MAX_BYTES; k++)
                        xfer_bytes[k] = fld[7 + k][7:0];
                    run_transfer(fld[2][0], fld[3][6:0], fld[4][0], fld[5][15:0],
                                 fld[6], fld[1]);
                end
            end
            $fclose(fd);
            if (cur_test != 0)
                print_test_result(cur_test, errors - test_errors);
        end

        for (k = 0; k < 20; k++) begin
            @(posedge dri_clk);
            check_value(i2c_done, 1'b0, "i2c_done with no transfer running");
        end
        $display("%0d tests, %0d transfers, %0d checks, %0d errors",
                 tests_run, transfers, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/i2c_master_trace.txt
// test gap rh_wl slave bit_ctrl word_addr reg_num, then reg_num data bytes, all hex
// data is write data when rh_wl is 0 and expected read data when it is 1
// slave 50 answers, 23 is absent and its bytes are placeholders
// test 2: single byte, 8-bit word address
2 4 0 50 0 0010 1 a5
2 4 1 50 0 0010 1 a5
// test 3: bursts of four and three
3 4 0 50 1 0120 4 11 22 33 44
3 4 1 50 1 0120 4 11 22 33 44
3 4 0 50 0 0040 3 9c 5e 07
3 4 1 50 0 0040 3 9c 5e 07
3 4 1 50 0 0021 2 22 33
// test 4: master acks over longer read bursts
4 4 0 50 0 0080 6 de ad be ef 01 02
4 4 1 50 0 0080 6 de ad be ef 01 02
4 4 1 50 1 0082 4 be ef 01 02
4 4 0 50 1 3a60 8 01 23 45 67 89 ab cd ef
4 4 1 50 1 3a60 8 01 23 45 67 89 ab cd ef
// test 5: absent slave, nothing written
5 4 0 23 0 0010 1 5c
5 4 0 23 1 0120 2 ff ff
5 4 1 23 0 0010 1 00
5 4 1 50 0 0010 1 a5
5 4 1 50 1 0120 2 11 22
// test 6: back to back, no idle gap
6 0 0 50 0 0030 2 c3 3c
6 0 1 50 0 0030 2 c3 3c
6 0 0 50 1 00f0 3 a1 b2 c3
6 0 1 50 1 00f0 3 a1 b2 c3
6 0 1 50 0 0031 1 3c
6 0 0 50 0 00fe 3 e7 18 66
6 0 1 50 0 00fe 3 e7 18 66
6 0 1 50 0 0010 1 a5

// File: tb.f
rtl/i2c_pkg.sv
rtl/i2c_step_timer.sv
rtl/i2c_ctrl_fsm.sv
rtl/i2c_bit_engine.sv
rtl/i2c_master_top.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv
